// File: hdl/gpu_config.svh
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

// Number of warp slots in one core
`define GPU_MAX_WARPS 2

// Register and data memory word width
`define GPU_DATA_WIDTH 32

`define GPU_IMEM_ADDR_WIDTH 8
`define GPU_DMEM_ADDR_WIDTH 8

// Registers per warp including the warp index register
`define GPU_NUM_REGS 8

`endif

// File: hdl/gpu_isa_pkg.sv
package gpu_isa_pkg;

    localparam int INSTR_WIDTH    = 32;
    localparam int OPCODE_WIDTH   = 4;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int IMM_WIDTH      = 16;

    // Low bit of each field in the instruction word
    localparam int OPCODE_LSB = 28;
    localparam int RD_LSB     = 25;
    localparam int RS1_LSB    = 22;
    localparam int RS2_LSB    = 19;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [INSTR_WIDTH-1:0]    instruction_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ADDI  = 4'h1,
        OP_ADD   = 4'h2,
        OP_SUB   = 4'h3,
        OP_BNE   = 4'h4,
        OP_LOAD  = 4'h5,
        OP_STORE = 4'h6,
        OP_HALT  = 4'hf
    } opcode_t;

endpackage

// File: hdl/gpu_core_pkg.sv
`include "gpu_config.svh"

package gpu_core_pkg;

    typedef logic [$clog2(`GPU_MAX_WARPS)-1:0]   warp_id_t;
    typedef logic [$clog2(`GPU_MAX_WARPS+1)-1:0] warp_count_t;

    typedef enum logic [2:0] {
        WARP_IDLE, WARP_FETCH, WARP_DECODE, WARP_REQUEST,
        WARP_WAIT, WARP_EXECUTE, WARP_UPDATE, WARP_DONE
    } warp_state_t;

    typedef enum logic [1:0] {FETCHER_IDLE, FETCHER_FETCHING, FETCHER_DONE} fetcher_state_t;

    typedef enum logic [1:0] {LSU_IDLE, LSU_REQUESTING, LSU_WAITING, LSU_DONE} lsu_state_t;

endpackage

// File: hdl/warp_fetcher.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module warp_fetcher
    import gpu_core_pkg::*, gpu_isa_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  warp_state_t                     warp_state,
    input  logic [`GPU_IMEM_ADDR_WIDTH-1:0] pc,
    input  logic                            instr_read_ready,
    input  instruction_t                    instr_read_data,
    output logic                            instr_read_valid,
    output logic [`GPU_IMEM_ADDR_WIDTH-1:0] instr_read_address,
    output fetcher_state_t                  fetcher_state,
    output instruction_t                    instruction
);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetcher_state <= FETCHER_IDLE;
            instr_read_valid <= 1'b0;
        end else begin
            case (fetcher_state)
                FETCHER_IDLE: begin
                    if (warp_state == WARP_FETCH) begin
                        fetcher_state <= FETCHER_FETCHING;
                        instr_read_valid <= 1'b1;
                        instr_read_address <= pc;
                    end
                end
                FETCHER_FETCHING: begin
                    // Word is taken in the ready cycle
                    if (instr_read_ready) begin
                        fetcher_state <= FETCHER_DONE;
                        instr_read_valid <= 1'b0;
                        instruction <= instr_read_data;
                    end
                end
                default: begin
                    if (warp_state == WARP_DECODE) begin
                        fetcher_state <= FETCHER_IDLE;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        instr_read_valid && !instr_read_ready
        |=> instr_read_valid && $stable(instr_read_address));

endmodule

// File: hdl/warp_decoder.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module warp_decoder
    import gpu_core_pkg::*, gpu_isa_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  warp_state_t                warp_state,
    input  instruction_t               instruction,
    output opcode_t                    opcode,
    output reg_addr_t                  rd,
    output reg_addr_t                  rs1,
    output reg_addr_t                  rs2,
    output logic [`GPU_DATA_WIDTH-1:0] immediate,
    output logic                       reg_write_enable,
    output logic                       mem_read_enable,
    output logic                       mem_write_enable,
    output logic                       branch,
    output logic                       halt
);

    opcode_t op;

    assign op = opcode_t'(instruction[OPCODE_LSB +: OPCODE_WIDTH]);

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_enable <= 1'b0;
            mem_read_enable <= 1'b0;
            mem_write_enable <= 1'b0;
            branch <= 1'b0;
            halt <= 1'b0;
        end else if (warp_state == WARP_DECODE) begin
            opcode <= op;
            rd <= instruction[RD_LSB +: REG_ADDR_WIDTH];
            rs1 <= instruction[RS1_LSB +: REG_ADDR_WIDTH];
            rs2 <= instruction[RS2_LSB +: REG_ADDR_WIDTH];
            // Sign extend the 16 bit immediate
            immediate <= {{(`GPU_DATA_WIDTH - IMM_WIDTH){instruction[IMM_WIDTH-1]}},
                          instruction[IMM_WIDTH-1:0]};
            reg_write_enable <= op inside {OP_ADDI, OP_ADD, OP_SUB, OP_LOAD};
            mem_read_enable <= (op == OP_LOAD);
            mem_write_enable <= (op == OP_STORE);
            branch <= (op == OP_BNE);
            halt <= (op == OP_HALT);
        end
    end

endmodule

// File: hdl/warp_reg_file.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module warp_reg_file
    import gpu_core_pkg::*, gpu_isa_pkg::*;
#(
    parameter int warp_index = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  warp_state_t                warp_state,
    input  logic                       reg_write_enable,
    input  reg_addr_t                  rd,
    input  reg_addr_t                  rs1,
    input  reg_addr_t                  rs2,
    input  logic [`GPU_DATA_WIDTH-1:0] alu_result,
    input  logic [`GPU_DATA_WIDTH-1:0] load_data,
    input  logic                       is_load,
    output logic [`GPU_DATA_WIDTH-1:0] rs1_data,
    output logic [`GPU_DATA_WIDTH-1:0] rs2_data
);

    // Top register reads back the warp index
    localparam reg_addr_t ID_REG = reg_addr_t'(`GPU_NUM_REGS - 1);

    logic [`GPU_DATA_WIDTH-1:0] regs [`GPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `GPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (warp_state == WARP_EXECUTE && reg_write_enable
                     && rd != '0 && rd != ID_REG) begin
            regs[rd] <= is_load ? load_data : alu_result;
        end
    end

    // r0 is never written so it stays zero
    assign rs1_data = (rs1 == ID_REG) ? `GPU_DATA_WIDTH'(warp_index) : regs[rs1];
    assign rs2_data = (rs2 == ID_REG) ? `GPU_DATA_WIDTH'(warp_index) : regs[rs2];

endmodule

// File: hdl/scalar_alu.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module scalar_alu
    import gpu_isa_pkg::*;
(
    input  opcode_t                    opcode,
    input  logic [`GPU_DATA_WIDTH-1:0] op1,
    input  logic [`GPU_DATA_WIDTH-1:0] op2,
    input  logic [`GPU_DATA_WIDTH-1:0] immediate,
    output logic [`GPU_DATA_WIDTH-1:0] result,
    output logic                       branch_taken
);

    always_comb begin
        case (opcode)
            OP_ADDI: result = op1 + immediate;
            OP_ADD:  result = op1 + op2;
            OP_SUB:  result = op1 - op2;
            default: result = '0;
        endcase
    end

    // Condition for bne
    assign branch_taken = (op1 != op2);

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module load_store_unit
    import gpu_core_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  warp_state_t                     warp_state,
    input  logic                            mem_read_enable,
    input  logic                            mem_write_enable,
    input  logic [`GPU_DATA_WIDTH-1:0]      base,
    input  logic [`GPU_DATA_WIDTH-1:0]      store_data,
    input  logic [`GPU_DATA_WIDTH-1:0]      immediate,
    input  logic                            data_read_ready,
    input  logic [`GPU_DATA_WIDTH-1:0]      data_read_data,
    input  logic                            data_write_ready,
    output logic                            data_read_valid,
    output logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_read_address,
    output logic                            data_write_valid,
    output logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_write_address,
    output logic [`GPU_DATA_WIDTH-1:0]      data_write_data,
    output lsu_state_t                      lsu_state,
    output logic [`GPU_DATA_WIDTH-1:0]      load_data
);

    logic [`GPU_DATA_WIDTH-1:0] address;

    assign address = base + immediate;

    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_state <= LSU_IDLE;
            data_read_valid <= 1'b0;
            data_write_valid <= 1'b0;
        end else begin
            case (lsu_state)
                LSU_IDLE: begin
                    if (warp_state == WARP_REQUEST && (mem_read_enable || mem_write_enable)) begin
                        lsu_state <= LSU_REQUESTING;
                    end
                end
                LSU_REQUESTING: begin
                    lsu_state <= LSU_WAITING;
                    if (mem_read_enable) begin
                        data_read_valid <= 1'b1;
                        data_read_address <= address[`GPU_DMEM_ADDR_WIDTH-1:0];
                    end else begin
                        data_write_valid <= 1'b1;
                        data_write_address <= address[`GPU_DMEM_ADDR_WIDTH-1:0];
                        data_write_data <= store_data;
                    end
                end
                LSU_WAITING: begin
                    // Hold the request until the memory accepts it
                    if (data_read_valid && data_read_ready) begin
                        data_read_valid <= 1'b0;
                        load_data <= data_read_data;
                        lsu_state <= LSU_DONE;
                    end else if (data_write_valid && data_write_ready) begin
                        data_write_valid <= 1'b0;
                        lsu_state <= LSU_DONE;
                    end
                end
                default: begin
                    if (warp_state == WARP_UPDATE) begin
                        lsu_state <= LSU_IDLE;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(data_read_valid && data_write_valid));

endmodule

// File: hdl/warp_scheduler.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module warp_scheduler
    import gpu_core_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  warp_count_t                     num_warps,
    input  logic [`GPU_IMEM_ADDR_WIDTH-1:0] base_address,
    input  fetcher_state_t                  fetcher_state [`GPU_MAX_WARPS],
    input  lsu_state_t                      lsu_state,
    input  logic                            halt,
    input  logic                            branch,
    input  logic                            branch_taken,
    input  logic [`GPU_DATA_WIDTH-1:0]      immediate,
    output warp_state_t                     warp_state [`GPU_MAX_WARPS],
    output logic [`GPU_IMEM_ADDR_WIDTH-1:0] pc [`GPU_MAX_WARPS],
    output warp_id_t                        current_warp,
    output logic                            done
);

    logic                            running;
    logic                            all_done;
    warp_id_t                        next_warp;
    warp_state_t                     current_state;
    logic [`GPU_IMEM_ADDR_WIDTH-1:0] next_pc;

    assign current_state = warp_state[current_warp];
    assign next_pc = (branch && branch_taken)
                   ? pc[current_warp] + immediate[`GPU_IMEM_ADDR_WIDTH-1:0]
                   : pc[current_warp] + 1'b1;

    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < `GPU_MAX_WARPS; i++) begin
            if (i < int'(num_warps) && warp_state[i] != WARP_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    // Nearest slot after the current one that has a decoded instruction
    // Idle slots never qualify, so inactive warps drop out by themselves
    always_comb begin
        int idx;
        next_warp = current_warp;
        for (int k = `GPU_MAX_WARPS - 1; k > 0; k--) begin
            idx = (int'(current_warp) + k) % `GPU_MAX_WARPS;
            if (warp_state[idx] inside {[WARP_DECODE:WARP_UPDATE]}) begin
                next_warp = warp_id_t'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done <= 1'b0;
            current_warp <= '0;
            for (int i = 0; i < `GPU_MAX_WARPS; i++) begin
                warp_state[i] <= WARP_IDLE;
                pc[i] <= '0;
            end
        end else if (!running) begin
            if (start) begin
                running <= 1'b1;
                current_warp <= '0;
                for (int i = 0; i < `GPU_MAX_WARPS; i++) begin
                    if (i < int'(num_warps)) begin
                        warp_state[i] <= WARP_FETCH;
                        pc[i] <= base_address;
                    end
                end
            end
        end else begin
            // DONE is final, so done holds until reset
            done <= all_done;
            // Fetches finish in parallel for every warp
            for (int i = 0; i < `GPU_MAX_WARPS; i++) begin
                if (warp_state[i] == WARP_FETCH && fetcher_state[i] == FETCHER_DONE) begin
                    warp_state[i] <= WARP_DECODE;
                end
            end
            if (current_state inside {WARP_FETCH, WARP_UPDATE, WARP_DONE}) begin
                current_warp <= next_warp;
            end
            case (current_state)
                WARP_DECODE:  warp_state[current_warp] <= WARP_REQUEST;
                WARP_REQUEST: warp_state[current_warp] <= WARP_WAIT;
                WARP_WAIT: begin
                    if (!(lsu_state inside {LSU_REQUESTING, LSU_WAITING})) begin
                        warp_state[current_warp] <= WARP_EXECUTE;
                    end
                end
                WARP_EXECUTE: warp_state[current_warp] <= WARP_UPDATE;
                WARP_UPDATE: begin
                    if (halt) begin
                        warp_state[current_warp] <= WARP_DONE;
                    end else begin
                        pc[current_warp] <= next_pc;
                        warp_state[current_warp] <= WARP_FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        running |-> current_warp < num_warps);

endmodule

// File: hdl/compute_core.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module compute_core
    import gpu_core_pkg::*, gpu_isa_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  warp_count_t                     num_warps,
    input  logic [`GPU_IMEM_ADDR_WIDTH-1:0] base_address,
    output logic                            done,
    input  logic [`GPU_MAX_WARPS-1:0]       instr_read_ready,
    input  instruction_t                    instr_read_data [`GPU_MAX_WARPS],
    output logic [`GPU_MAX_WARPS-1:0]       instr_read_valid,
    output logic [`GPU_IMEM_ADDR_WIDTH-1:0] instr_read_address [`GPU_MAX_WARPS],
    input  logic                            data_read_ready,
    input  logic [`GPU_DATA_WIDTH-1:0]      data_read_data,
    input  logic                            data_write_ready,
    output logic                            data_read_valid,
    output logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_read_address,
    output logic                            data_write_valid,
    output logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_write_address,
    output logic [`GPU_DATA_WIDTH-1:0]      data_write_data
);

    warp_state_t                     warp_state [`GPU_MAX_WARPS];
    logic [`GPU_IMEM_ADDR_WIDTH-1:0] pc [`GPU_MAX_WARPS];
    fetcher_state_t                  fetcher_state [`GPU_MAX_WARPS];
    instruction_t                    instruction [`GPU_MAX_WARPS];
    opcode_t                         opcode [`GPU_MAX_WARPS];
    reg_addr_t                       rd [`GPU_MAX_WARPS];
    reg_addr_t                       rs1 [`GPU_MAX_WARPS];
    reg_addr_t                       rs2 [`GPU_MAX_WARPS];
    logic [`GPU_DATA_WIDTH-1:0]      immediate [`GPU_MAX_WARPS];
    logic [`GPU_DATA_WIDTH-1:0]      rs1_data [`GPU_MAX_WARPS];
    logic [`GPU_DATA_WIDTH-1:0]      rs2_data [`GPU_MAX_WARPS];
    logic [`GPU_MAX_WARPS-1:0]       reg_write_enable;
    logic [`GPU_MAX_WARPS-1:0]       mem_read_enable;
    logic [`GPU_MAX_WARPS-1:0]       mem_write_enable;
    logic [`GPU_MAX_WARPS-1:0]       branch;
    logic [`GPU_MAX_WARPS-1:0]       halt;

    warp_id_t                        current_warp;
    logic [`GPU_DATA_WIDTH-1:0]      alu_result;
    logic [`GPU_DATA_WIDTH-1:0]      load_data;
    logic                            branch_taken;
    lsu_state_t                      lsu_state;

    warp_scheduler u_warp_scheduler (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .num_warps    (num_warps),
        .base_address (base_address),
        .fetcher_state(fetcher_state),
        .lsu_state    (lsu_state),
        .halt         (halt[current_warp]),
        .branch       (branch[current_warp]),
        .branch_taken (branch_taken),
        .immediate    (immediate[current_warp]),
        .warp_state   (warp_state),
        .pc           (pc),
        .current_warp (current_warp),
        .done         (done)
    );

    // Private front end and registers for each warp slot
    for (genvar i = 0; i < `GPU_MAX_WARPS; i++) begin : g_warp
        warp_fetcher u_warp_fetcher (
            .clk               (clk),
            .reset             (reset),
            .warp_state        (warp_state[i]),
            .pc                (pc[i]),
            .instr_read_ready  (instr_read_ready[i]),
            .instr_read_data   (instr_read_data[i]),
            .instr_read_valid  (instr_read_valid[i]),
            .instr_read_address(instr_read_address[i]),
            .fetcher_state     (fetcher_state[i]),
            .instruction       (instruction[i])
        );

        warp_decoder u_warp_decoder (
            .clk             (clk),
            .reset           (reset),
            .warp_state      (warp_state[i]),
            .instruction     (instruction[i]),
            .opcode          (opcode[i]),
            .rd              (rd[i]),
            .rs1             (rs1[i]),
            .rs2             (rs2[i]),
            .immediate       (immediate[i]),
            .reg_write_enable(reg_write_enable[i]),
            .mem_read_enable (mem_read_enable[i]),
            .mem_write_enable(mem_write_enable[i]),
            .branch          (branch[i]),
            .halt            (halt[i])
        );

        warp_reg_file #(
            .warp_index(i)
        ) u_warp_reg_file (
            .clk             (clk),
            .reset           (reset),
            .warp_state      (warp_state[i]),
            .reg_write_enable(reg_write_enable[i]),
            .rd              (rd[i]),
            .rs1             (rs1[i]),
            .rs2             (rs2[i]),
            .alu_result      (alu_result),
            .load_data       (load_data),
            .is_load         (mem_read_enable[i]),
            .rs1_data        (rs1_data[i]),
            .rs2_data        (rs2_data[i])
        );
    end

    // Shared units see only the selected warp
    scalar_alu u_scalar_alu (
        .opcode      (opcode[current_warp]),
        .op1         (rs1_data[current_warp]),
        .op2         (rs2_data[current_warp]),
        .immediate   (immediate[current_warp]),
        .result      (alu_result),
        .branch_taken(branch_taken)
    );

    load_store_unit u_load_store_unit (
        .clk               (clk),
        .reset             (reset),
        .warp_state        (warp_state[current_warp]),
        .mem_read_enable   (mem_read_enable[current_warp]),
        .mem_write_enable  (mem_write_enable[current_warp]),
        .base              (rs1_data[current_warp]),
        .store_data        (rs2_data[current_warp]),
        .immediate         (immediate[current_warp]),
        .data_read_ready   (data_read_ready),
        .data_read_data    (data_read_data),
        .data_write_ready  (data_write_ready),
        .data_read_valid   (data_read_valid),
        .data_read_address (data_read_address),
        .data_write_valid  (data_write_valid),
        .data_write_address(data_write_address),
        .data_write_data   (data_write_data),
        .lsu_state         (lsu_state),
        .load_data         (load_data)
    );

endmodule

// File: bench/core_memory_model.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module core_memory_model
    import gpu_isa_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  int                              max_delay,
    input  logic [`GPU_MAX_WARPS-1:0]       instr_read_valid,
    input  logic [`GPU_IMEM_ADDR_WIDTH-1:0] instr_read_address [`GPU_MAX_WARPS],
    output logic [`GPU_MAX_WARPS-1:0]       instr_read_ready,
    output instruction_t                    instr_read_data [`GPU_MAX_WARPS],
    input  logic                            data_read_valid,
    input  logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_read_address,
    output logic                            data_read_ready,
    output logic [`GPU_DATA_WIDTH-1:0]      data_read_data,
    input  logic                            data_write_valid,
    input  logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_write_address,
    input  logic [`GPU_DATA_WIDTH-1:0]      data_write_data,
    output logic                            data_write_ready
);

    instruction_t               rom [2**`GPU_IMEM_ADDR_WIDTH];
    logic [`GPU_DATA_WIDTH-1:0] dmem [2**`GPU_DMEM_ADDR_WIDTH];

    integer                    seed = 11;
    logic [`GPU_MAX_WARPS-1:0] instr_busy;
    int                        instr_delay [`GPU_MAX_WARPS];
    logic                      data_busy;
    int                        data_delay;

    // Wait states before ready range from 0 to max_delay
    function automatic int random_delay();
        return {$random(seed)} % (max_delay + 1);
    endfunction

    initial begin
        instr_read_ready = '0;
        data_read_ready = 1'b0;
        data_write_ready = 1'b0;
        data_read_data = '0;
        for (int i = 0; i < `GPU_MAX_WARPS; i++) begin
            instr_read_data[i] = '0;
        end
    end

    // All ports draw their delays from one seed in a fixed order
    always @(posedge clk) begin
        for (int i = 0; i < `GPU_MAX_WARPS; i++) begin
            if (reset || instr_read_ready[i]) begin
                instr_read_ready[i] <= 1'b0;
                instr_busy[i] <= 1'b0;
            end else if (instr_read_valid[i] && !instr_busy[i]) begin
                instr_busy[i] <= 1'b1;
                instr_delay[i] <= random_delay();
            end else if (instr_busy[i] && instr_delay[i] == 0) begin
                instr_read_ready[i] <= 1'b1;
                instr_read_data[i] <= rom[instr_read_address[i]];
            end else if (instr_busy[i]) begin
                instr_delay[i] <= instr_delay[i] - 1;
            end
        end

        if (reset || data_read_ready || data_write_ready) begin
            data_read_ready <= 1'b0;
            data_write_ready <= 1'b0;
            data_busy <= 1'b0;
        end else if ((data_read_valid || data_write_valid) && !data_busy) begin
            data_busy <= 1'b1;
            data_delay <= random_delay();
        end else if (data_busy && data_delay == 0) begin
            if (data_read_valid) begin
                data_read_ready <= 1'b1;
                data_read_data <= dmem[data_read_address];
            end else begin
                // Write lands together with ready
                data_write_ready <= 1'b1;
                dmem[data_write_address] <= data_write_data;
            end
        end else if (data_busy) begin
            data_delay <= data_delay - 1;
        end
    end

endmodule

// File: bench/compute_core_tb.sv
`timescale 1ns/10ps
`include "gpu_config.svh"

module compute_core_tb
    import gpu_isa_pkg::*, gpu_core_pkg::*;
();

    localparam int NUM_ROWS       = 5;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int ID_REG         = 7;
    localparam logic [`GPU_IMEM_ADDR_WIDTH-1:0] KERNEL_BASE = 8'h20;

    // One stimulus table row per kernel launch
    int row_warps [NUM_ROWS] = '{1, 2, 2, 1, 2};
    int row_n     [NUM_ROWS] = '{4, 4, 4, 6, 1};
    int row_delay [NUM_ROWS] = '{0, 0, 7, 7, 3};

    logic                            clk;
    logic                            reset;
    logic                            start;
    warp_count_t                     num_warps;
    logic [`GPU_IMEM_ADDR_WIDTH-1:0] base_address;
    logic                            done;
    int                              max_delay;
    logic [`GPU_MAX_WARPS-1:0]       instr_read_ready;
    instruction_t                    instr_read_data [`GPU_MAX_WARPS];
    logic [`GPU_MAX_WARPS-1:0]       instr_read_valid;
    logic [`GPU_IMEM_ADDR_WIDTH-1:0] instr_read_address [`GPU_MAX_WARPS];
    logic                            data_read_ready;
    logic [`GPU_DATA_WIDTH-1:0]      data_read_data;
    logic                            data_write_ready;
    logic                            data_read_valid;
    logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_read_address;
    logic                            data_write_valid;
    logic [`GPU_DMEM_ADDR_WIDTH-1:0] data_write_address;
    logic [`GPU_DATA_WIDTH-1:0]      data_write_data;

    compute_core u_compute_core (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .num_warps         (num_warps),
        .base_address      (base_address),
        .done              (done),
        .instr_read_ready  (instr_read_ready),
        .instr_read_data   (instr_read_data),
        .instr_read_valid  (instr_read_valid),
        .instr_read_address(instr_read_address),
        .data_read_ready   (data_read_ready),
        .data_read_data    (data_read_data),
        .data_write_ready  (data_write_ready),
        .data_read_valid   (data_read_valid),
        .data_read_address (data_read_address),
        .data_write_valid  (data_write_valid),
        .data_write_address(data_write_address),
        .data_write_data   (data_write_data)
    );

    core_memory_model u_core_memory_model (
        .clk               (clk),
        .reset             (reset),
        .max_delay         (max_delay),
        .instr_read_valid  (instr_read_valid),
        .instr_read_address(instr_read_address),
        .instr_read_ready  (instr_read_ready),
        .instr_read_data   (instr_read_data),
        .data_read_valid   (data_read_valid),
        .data_read_address (data_read_address),
        .data_read_ready   (data_read_ready),
        .data_read_data    (data_read_data),
        .data_write_valid  (data_write_valid),
        .data_write_address(data_write_address),
        .data_write_data   (data_write_data),
        .data_write_ready  (data_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Opcode, rd, rs1, rs2, three spare bits, then the 16 bit immediate
    function automatic instruction_t encode_instr(opcode_t op, int rd, int rs1, int rs2, int imm);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s actual %0h expected %0h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Timeout: done did not rise within %0d cycles", limit);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic load_kernel();
        // Unused words halt and carry their own address as immediate
        for (int a = 0; a < 2**`GPU_IMEM_ADDR_WIDTH; a++) begin
            u_core_memory_model.rom[a] = encode_instr(OP_HALT, 0, 0, 0, a);
        end
        u_core_memory_model.rom[KERNEL_BASE + 0] = encode_instr(OP_LOAD, 1, 0, 0, 16);
        u_core_memory_model.rom[KERNEL_BASE + 1] = encode_instr(OP_ADDI, 4, 0, 0, 1);
        u_core_memory_model.rom[KERNEL_BASE + 2] = encode_instr(OP_ADD, 3, 1, 0, 0);
        // Loop body sums n down to 1 into r2
        u_core_memory_model.rom[KERNEL_BASE + 3] = encode_instr(OP_ADD, 2, 2, 3, 0);
        u_core_memory_model.rom[KERNEL_BASE + 4] = encode_instr(OP_SUB, 3, 3, 4, 0);
        u_core_memory_model.rom[KERNEL_BASE + 5] = encode_instr(OP_BNE, 0, 3, 0, -2);
        u_core_memory_model.rom[KERNEL_BASE + 6] = encode_instr(OP_ADD, 2, 2, ID_REG, 0);
        u_core_memory_model.rom[KERNEL_BASE + 7] = encode_instr(OP_STORE, 0, ID_REG, 2, 32);
        u_core_memory_model.rom[KERNEL_BASE + 8] = encode_instr(OP_ADDI, 5, 1, 0, 5);
        u_core_memory_model.rom[KERNEL_BASE + 9] = encode_instr(OP_STORE, 0, ID_REG, 5, 48);
        u_core_memory_model.rom[KERNEL_BASE + 10] = encode_instr(OP_HALT, 0, 0, 0, 0);
    endtask

    task automatic run_row(input int warps, input int n, input int delay);
        @(posedge clk);
        reset <= 1'b1;
        start <= 1'b0;
        num_warps <= warp_count_t'(warps);
        base_address <= KERNEL_BASE;
        max_delay <= delay;
        for (int a = 0; a < 2**`GPU_DMEM_ADDR_WIDTH; a++) begin
            u_core_memory_model.dmem[a] = 32'h1000_0000 + a;
        end
        u_core_memory_model.dmem[16] = n;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_equal("done", done, 1'b0);
        check_equal("instr_read_valid", instr_read_valid, '0);
        check_equal("data_read_valid", data_read_valid, 1'b0);
        check_equal("data_write_valid", data_write_valid, 1'b0);

        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_done(TIMEOUT_CYCLES);

        // Done must hold once raised
        repeat (20) begin
            @(negedge clk);
            check_equal("done", done, 1'b1);
        end

        for (int w = 0; w < `GPU_MAX_WARPS; w++) begin
            if (w < warps) begin
                check_equal($sformatf("dmem[%0d]", 32 + w), u_core_memory_model.dmem[32 + w],
                            n * (n + 1) / 2 + w);
                check_equal($sformatf("dmem[%0d]", 48 + w), u_core_memory_model.dmem[48 + w],
                            n + 5);
            end else begin
                check_equal($sformatf("dmem[%0d]", 32 + w), u_core_memory_model.dmem[32 + w],
                            32'h1000_0000 + 32 + w);
                check_equal($sformatf("dmem[%0d]", 48 + w), u_core_memory_model.dmem[48 + w],
                            32'h1000_0000 + 48 + w);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        num_warps = '0;
        base_address = '0;
        max_delay = 0;
        load_kernel();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(row_warps[r], row_n[r], row_delay[r]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/gpu_isa_pkg.sv
hdl/gpu_core_pkg.sv
hdl/warp_fetcher.sv
hdl/warp_decoder.sv
hdl/warp_reg_file.sv
hdl/scalar_alu.sv
hdl/load_store_unit.sv
hdl/warp_scheduler.sv
hdl/compute_core.sv
bench/core_memory_model.sv
bench/compute_core_tb.sv

// File: Bender.yml
package:
  name: compute_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gpu_isa_pkg.sv
      - hdl/gpu_core_pkg.sv
      - hdl/warp_fetcher.sv
      - hdl/warp_decoder.sv
      - hdl/warp_reg_file.sv
      - hdl/scalar_alu.sv
      - hdl/load_store_unit.sv
      - hdl/warp_scheduler.sv
      - hdl/compute_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/core_memory_model.sv
      - bench/compute_core_tb.sv
